// File: common/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// data word and instruction width
`define CPU_XLEN 16

// general purpose registers, r0 included
`define CPU_NREGS 8

// data memory depth in words
`define CPU_DMEM_WORDS 32

// pc value after reset
`define CPU_RESET_PC 0

`endif

// File: common/cpu_pkg.sv
`include "cpu_defines.svh"

package cpu_pkg;

    // immediate form of an instruction word
    typedef struct packed {
        logic [4:0] opcode;
        logic [2:0] rs;
        logic [2:0] rt;
        logic [4:0] imm;
    } instr_imm_t;

    // register form, low bits hold a second source and a function code
    typedef struct packed {
        logic [4:0] opcode;
        logic [2:0] rs;
        logic [2:0] rt;
        logic [2:0] rs2;
        logic [1:0] func;
    } instr_reg_t;

    typedef union packed {
        instr_imm_t i;
        instr_reg_t r;
    } instr_t;

    // OR is reserved, the decoder never selects it
    typedef enum logic [2:0] {
        ALU_ROTL = 3'b000,
        ALU_SHL  = 3'b001,
        ALU_ROTR = 3'b010,
        ALU_SHR  = 3'b011,
        ALU_ADD  = 3'b100,
        ALU_OR   = 3'b101,
        ALU_XOR  = 3'b110,
        ALU_AND  = 3'b111
    } alu_op_t;

    typedef struct packed {
        logic       regdst;
        logic       jump;
        logic       branch;
        logic       memread;
        logic       memtoreg;
        logic       memwrite;
        logic       alusrc;
        logic       regwrite;
        logic       btr;
        logic       set;
        logic [1:0] opoption;
        alu_op_t    aluop;
    } ctrl_t;

    // register write at retire
    typedef struct packed {
        logic                           valid;
        logic [$clog2(`CPU_NREGS)-1:0]  idx;
        logic [`CPU_XLEN-1:0]           data;
    } wb_t;

    // data memory store
    typedef struct packed {
        logic                               valid;
        logic [$clog2(`CPU_DMEM_WORDS)-1:0] addr;
        logic [`CPU_XLEN-1:0]               data;
    } mem_wr_t;

endpackage

// File: hw/control_unit.sv
module control_unit (
    input  cpu_pkg::instr_t instr,
    output cpu_pkg::ctrl_t  ctrl
);

    logic o4;
    logic o3;
    logic o2;
    logic o1;
    logic o0;

    assign o4 = instr.r.opcode[4];
    assign o3 = instr.r.opcode[3];
    assign o2 = instr.r.opcode[2];
    assign o1 = instr.r.opcode[1];
    assign o0 = instr.r.opcode[0];

    always_comb begin
        ctrl = '0;

        // rs is the destination for imm alu, 10010, rotates/shifts and set
        ctrl.regdst = (~o4 & o3 & ~o2) |
                      (o4 & ~o3 & ~o2 & o1 & ~o0) |
                      (o4 & o2);

        ctrl.jump   = ~o4 & ~o3 & o2;
        ctrl.branch = ~o4 & o3 & o2;

        // only 10001 loads
        ctrl.memread  = o4 & ~o3 & ~o2 & ~o1 & o0;
        ctrl.memtoreg = o4 & ~o3 & ~o2 & ~o1 & o0;

        // 10000 and 10011
        ctrl.memwrite = o4 & ~o3 & ~o2 & ~(o1 ^ o0);

        ctrl.alusrc = (~o4 & o2) |
                      (o4 ^ o3) |
                      (o3 & ~o2 & ~o1 & ~o0);

        // stores and branches write nothing
        ctrl.regwrite = (~o4 & o3 & ~o2) |
                        (~o4 & ~o3 & o2 & o1) |
                        (o4 & o3) |
                        (o4 & ~o3 & o2) |
                        (o4 & ~o3 & ~o2 & (o1 ^ o0));

        ctrl.btr      = o4 & o3 & ~o2 & ~o1 & o0;
        ctrl.set      = o4 & o3 & o2;
        ctrl.opoption = {o4, o3};

        // in immediate forms the func bits are imm bits and don't matter
        casez ({instr.r.opcode, instr.r.func})
            7'b10100??, 7'b1101000: begin
                ctrl.aluop = cpu_pkg::ALU_ROTL;
            end
            7'b10101??, 7'b1101001: begin
                ctrl.aluop = cpu_pkg::ALU_SHL;
            end
            7'b10110??, 7'b1101010: begin
                ctrl.aluop = cpu_pkg::ALU_ROTR;
            end
            7'b10111??, 7'b1101011: begin
                ctrl.aluop = cpu_pkg::ALU_SHR;
            end
            7'b01?0???, 7'b1000???, 7'b10010??, 7'b10011??, 7'b11000??, 7'b110110?: begin
                ctrl.aluop = cpu_pkg::ALU_ADD;
            end
            7'b01010??, 7'b1101110, 7'b11100??: begin
                ctrl.aluop = cpu_pkg::ALU_XOR;
            end
            7'b01011??, 7'b1101111: begin
                ctrl.aluop = cpu_pkg::ALU_AND;
            end
            default: begin
                ctrl.aluop = cpu_pkg::ALU_ROTL;
            end
        endcase
    end

endmodule

// File: hw/alu.sv
`include "cpu_defines.svh"

module alu (
    input  cpu_pkg::alu_op_t     op,
    input  logic [`CPU_XLEN-1:0] a,
    input  logic [`CPU_XLEN-1:0] b,
    output logic [`CPU_XLEN-1:0] result
);

    localparam int W = `CPU_XLEN;

    logic [3:0]     amt;
    logic [2*W-1:0] dbl;
    logic [2*W-1:0] rot;

    assign amt = b[3:0];

    // rotates shift a doubled copy of a and keep one half
    assign dbl = {a, a};

    always_comb begin
        rot    = '0;
        result = '0;
        case (op)
            cpu_pkg::ALU_ROTL: begin
                rot    = dbl << amt;
                result = rot[2*W-1:W];
            end
            cpu_pkg::ALU_SHL: begin
                result = a << amt;
            end
            cpu_pkg::ALU_ROTR: begin
                rot    = dbl >> amt;
                result = rot[W-1:0];
            end
            cpu_pkg::ALU_SHR: begin
                result = a >> amt;
            end
            cpu_pkg::ALU_ADD: begin
                result = a + b;
            end
            cpu_pkg::ALU_OR: begin
                result = a | b;
            end
            cpu_pkg::ALU_XOR: begin
                result = a ^ b;
            end
            cpu_pkg::ALU_AND: begin
                result = a & b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: hw/reg_file.sv
`include "cpu_defines.svh"

module reg_file (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [$clog2(`CPU_NREGS)-1:0] rd_addr_a,
    input  logic [$clog2(`CPU_NREGS)-1:0] rd_addr_b,
    output logic [`CPU_XLEN-1:0]          rd_data_a,
    output logic [`CPU_XLEN-1:0]          rd_data_b,
    input  cpu_pkg::wb_t                  wr
);

    logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

    // r0 is an ordinary register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `CPU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.valid) begin
            regs[wr.idx] <= wr.data;
        end
    end

    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

endmodule

// File: hw/data_mem.sv
`include "cpu_defines.svh"

module data_mem (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic [$clog2(`CPU_DMEM_WORDS)-1:0] addr,
    output logic [`CPU_XLEN-1:0]               rd_data,
    input  cpu_pkg::mem_wr_t                   wr
);

    logic [`CPU_XLEN-1:0] mem [`CPU_DMEM_WORDS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `CPU_DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wr.valid) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // combinational read
    assign rd_data = mem[addr];

endmodule

// File: hw/result_select.sv
`include "cpu_defines.svh"

module result_select (
    input  cpu_pkg::ctrl_t       ctrl,
    input  logic [1:0]           opcode_lo,
    input  logic [`CPU_XLEN-1:0] alu_result,
    input  logic [`CPU_XLEN-1:0] mem_data,
    input  logic [`CPU_XLEN-1:0] rs_data,
    input  logic [`CPU_XLEN-1:0] rt_data,
    input  logic [`CPU_XLEN-1:0] link,
    output logic [`CPU_XLEN-1:0] wb_data,
    output logic                 branch_taken
);

    localparam int W = `CPU_XLEN;

    logic [W-1:0] rs_rev;
    logic         set_bit;
    logic         cond;

    always_comb begin
        for (int i = 0; i < W; i++) begin
            rs_rev[i] = rs_data[W-1-i];
        end
    end

    // bit 0 picks equal or signed less-than
    assign set_bit = opcode_lo[0] ? ($signed(rs_data) < $signed(rt_data))
                                  : ((rs_data ^ rt_data) == '0);

    always_comb begin
        case (opcode_lo)
            2'b00:   cond = (rs_data == '0);
            2'b01:   cond = (rs_data != '0);
            2'b10:   cond = rs_data[W-1];
            default: cond = ~rs_data[W-1];
        endcase
    end

    assign branch_taken = ctrl.branch & cond;

    always_comb begin
        if (ctrl.memtoreg) begin
            wb_data = mem_data;
        end else if (ctrl.jump && ctrl.regwrite) begin
            wb_data = link;
        end else if (ctrl.btr) begin
            wb_data = rs_rev;
        end else if (ctrl.set) begin
            wb_data = W'(set_bit);
        end else begin
            wb_data = alu_result;
        end
    end

endmodule

// File: hw/cpu_top.sv
`include "cpu_defines.svh"

module cpu_top (
    input  logic                 clk,
    input  logic                 arst_n,
    output logic [`CPU_XLEN-1:0] pc,
    input  logic [`CPU_XLEN-1:0] instr,
    output cpu_pkg::wb_t         retire,
    output cpu_pkg::mem_wr_t     store
);

    localparam int W  = `CPU_XLEN;
    localparam int RA = $clog2(`CPU_NREGS);
    localparam int MA = $clog2(`CPU_DMEM_WORDS);

    cpu_pkg::instr_t instr_u;
    cpu_pkg::ctrl_t  ctrl;

    logic          running;
    logic [W-1:0]  imm_sext;
    logic [W-1:0]  link;
    logic [W-1:0]  target;
    logic [W-1:0]  next_pc;
    logic [RA-1:0] rd_addr_b;
    logic [RA-1:0] dest;
    logic [W-1:0]  rs_data;
    logic [W-1:0]  rb_data;
    logic [W-1:0]  op_b;
    logic [W-1:0]  alu_result;
    logic [W-1:0]  mem_data;
    logic [W-1:0]  wb_data;
    logic          branch_taken;

    assign instr_u  = instr;
    assign imm_sext = {{(W-5){instr_u.i.imm[4]}}, instr_u.i.imm};
    assign link     = pc + W'(1);
    assign target   = link + imm_sext;

    control_unit u_control_unit (
        .instr (instr_u),
        .ctrl  (ctrl)
    );

    // stores and set read rt on port b, register alu ops read rs2
    assign rd_addr_b = (ctrl.alusrc || ctrl.set) ? instr_u.r.rt : instr_u.r.rs2;
    assign dest      = ctrl.regdst ? instr_u.r.rs : instr_u.r.rt;

    reg_file u_reg_file (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_addr_a (instr_u.r.rs),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rs_data),
        .rd_data_b (rb_data),
        .wr        (retire)
    );

    assign op_b = ctrl.alusrc ? imm_sext : rb_data;

    alu u_alu (
        .op     (ctrl.aluop),
        .a      (rs_data),
        .b      (op_b),
        .result (alu_result)
    );

    data_mem u_data_mem (
        .clk     (clk),
        .arst_n  (arst_n),
        .addr    (alu_result[MA-1:0]),
        .rd_data (mem_data),
        .wr      (store)
    );

    result_select u_result_select (
        .ctrl         (ctrl),
        .opcode_lo    (instr_u.r.opcode[1:0]),
        .alu_result   (alu_result),
        .mem_data     (mem_data),
        .rs_data      (rs_data),
        .rt_data      (rb_data),
        .link         (link),
        .wb_data      (wb_data),
        .branch_taken (branch_taken)
    );

    // strobes stay low until the core leaves reset
    assign retire.valid = running & ctrl.regwrite;
    assign retire.idx   = dest;
    assign retire.data  = wb_data;

    assign store.valid = running & ctrl.memwrite;
    assign store.addr  = alu_result[MA-1:0];
    assign store.data  = rb_data;

    always_comb begin
        if (!running) begin
            next_pc = pc;
        end else if (ctrl.jump || branch_taken) begin
            next_pc = target;
        end else begin
            next_pc = link;
        end
    end

    // first edge after reset release only arms the core, pc holds
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc      <= W'(`CPU_RESET_PC);
            running <= 1'b0;
        end else begin
            pc      <= next_pc;
            running <= 1'b1;
        end
    end

endmodule

// File: test/cpu_checker.sv
`include "cpu_defines.svh"

module cpu_checker (
    input logic                 clk,
    input logic                 arst_n,
    input logic [`CPU_XLEN-1:0] pc,
    input cpu_pkg::wb_t         retire,
    input cpu_pkg::mem_wr_t     store,
    input cpu_pkg::ctrl_t       ctrl,
    input logic                 branch_taken,
    input logic                 running
);

    strobes_low_in_reset: assert property (@(posedge clk)
        !arst_n |-> (!retire.valid && !store.valid))
        else $error("retire or store strobe active during reset");

    // stores never write a register
    store_without_write: assert property (@(posedge clk) disable iff (!arst_n)
        !(store.valid && retire.valid))
        else $error("store and register write in the same cycle");

    pc_steps_by_one: assert property (@(posedge clk) disable iff (!arst_n)
        (running && !ctrl.jump && !branch_taken) |=> (pc == $past(pc) + 16'd1))
        else $error("pc did not advance by one on sequential flow");

endmodule

bind cpu_top cpu_checker checker_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .pc           (pc),
    .retire       (retire),
    .store        (store),
    .ctrl         (ctrl),
    .branch_taken (branch_taken),
    .running      (running)
);

// File: test/cpu_tb.sv
`include "cpu_defines.svh"

module cpu_tb;

    localparam int W = `CPU_XLEN;
    localparam logic [W-1:0] RESET_PC = W'(`CPU_RESET_PC);

    // add-immediate into r1 and a store of r2, both presented while reset is held
    localparam logic [W-1:0] RESET_WRITE_INSTR = 16'h9101;
    localparam logic [W-1:0] RESET_STORE_INSTR = 16'h8141;

    logic             clk;
    logic             arst_n;
    logic [W-1:0]     pc;
    logic [W-1:0]     instr;
    cpu_pkg::wb_t     retire;
    cpu_pkg::mem_wr_t store;

    logic [W-1:0] imem [256];
    logic [W-1:0] m_reg [`CPU_NREGS];
    logic [W-1:0] m_mem [`CPU_DMEM_WORDS];
    logic [W-1:0] m_pc;
    logic         m_armed;
    int           errors;
    int           seed;

    cpu_top dut_i (
        .clk    (clk),
        .arst_n (arst_n),
        .pc     (pc),
        .instr  (instr),
        .retire (retire),
        .store  (store)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [W-1:0] shift_ref(input logic [1:0] kind, input logic [W-1:0] v,
                                                input logic [3:0] n);
        case (kind)
            2'd0:    return (v << n) | (v >> (W - n));
            2'd1:    return v << n;
            2'd2:    return (v >> n) | (v << (W - n));
            default: return v >> n;
        endcase
    endfunction

    function automatic logic [W-1:0] reverse(input logic [W-1:0] v);
        logic [W-1:0] r;
        for (int i = 0; i < W; i++) begin
            r[W-1-i] = v[i];
        end
        return r;
    endfunction

    task automatic report_mismatch(input string name, input logic [W-1:0] expected,
                                   input logic [W-1:0] actual);
        errors++;
        $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
    endtask

    // one instruction of the reference model, checked against the DUT
    task automatic step_and_check();
        logic [W-1:0] iw, a, b, r2, imm, link, nxt, wdata;
        logic [4:0]   opc;
        logic [4:0]   saddr;
        logic [2:0]   widx;
        logic         wv, sv, cond;
        iw    = imem[m_pc[7:0]];
        opc   = iw[15:11];
        a     = m_reg[iw[10:8]];
        b     = m_reg[iw[7:5]];
        r2    = m_reg[iw[4:2]];
        imm   = {{(W-5){iw[4]}}, iw[4:0]};
        link  = m_pc + 16'd1;
        saddr = 5'(a + imm);
        wv    = 1'b1;
        widx  = iw[10:8];
        casez (opc)
            5'b0011?, 5'b10001, 5'b11000, 5'b11001, 5'b1101?: widx = iw[7:5];
            5'b010??, 5'b10010, 5'b101??, 5'b111??: widx = iw[10:8];
            default: wv = 1'b0;
        endcase
        casez (opc)
            5'b0011?: wdata = link;
            5'b0100?, 5'b10010, 5'b11000: wdata = a + imm;
            5'b01010: wdata = a ^ imm;
            5'b01011: wdata = a & imm;
            5'b10001: wdata = m_mem[saddr];
            5'b101??: wdata = shift_ref(opc[1:0], a, imm[3:0]);
            5'b11001: wdata = reverse(a);
            5'b11010: wdata = shift_ref(iw[1:0], a, r2[3:0]);
            5'b11011: wdata = iw[1] ? (iw[0] ? a & r2 : a ^ r2) : a + r2;
            5'b111??: wdata = (opc[0] ? ($signed(a) < $signed(b)) : (a == b)) ? 16'd1 : 16'd0;
            default: wdata = '0;
        endcase
        sv   = (opc == 5'b10000) || (opc == 5'b10011);
        cond = opc[1] ? (a[W-1] ^ opc[0]) : ((a == '0) ^ opc[0]);
        nxt  = (opc[4:2] == 3'b001 || (opc[4:2] == 3'b011 && cond)) ? link + imm : link;

        if (pc !== m_pc) report_mismatch("pc", m_pc, pc);
        if (retire.valid !== wv) report_mismatch("retire.valid", W'(wv), W'(retire.valid));
        if (wv && retire.idx !== widx) report_mismatch("retire.idx", W'(widx), W'(retire.idx));
        if (wv && retire.data !== wdata) report_mismatch("retire.data", wdata, retire.data);
        if (store.valid !== sv) report_mismatch("store.valid", W'(sv), W'(store.valid));
        if (sv && store.addr !== saddr) report_mismatch("store.addr", W'(saddr), W'(store.addr));
        if (sv && store.data !== b) report_mismatch("store.data", b, store.data);

        if (wv) m_reg[widx] = wdata;
        if (sv) m_mem[saddr] = b;
        m_pc = nxt;
    endtask

    task automatic run_cycle();
        instr = imem[pc[7:0]];
        #25;
        if (m_armed) begin
            step_and_check();
        end else begin
            // first cycle after release only arms the core
            if (pc !== RESET_PC) report_mismatch("pc", RESET_PC, pc);
            if (retire.valid !== 1'b0) report_mismatch("retire.valid", '0, W'(retire.valid));
            if (store.valid !== 1'b0) report_mismatch("store.valid", '0, W'(store.valid));
            m_armed = 1'b1;
        end
        @(negedge clk);
    endtask

    initial begin
        logic [W-1:0] word;
        int           w;
        seed    = 32'h9f47_9f41;
        errors  = 0;
        m_armed = 1'b0;
        m_pc    = RESET_PC;
        arst_n  = 1'b0;
        instr   = '0;
        for (int i = 0; i < `CPU_NREGS; i++) m_reg[i] = '0;
        for (int i = 0; i < `CPU_DMEM_WORDS; i++) m_mem[i] = '0;
        // every opcode is defined, jumps and branches only go forward
        for (int i = 0; i < 256; i++) begin
            word = 16'($random(seed));
            if (word[15:13] == 3'b001 || word[15:13] == 3'b011) word[4] = 1'b0;
            imem[i] = word;
        end

        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            #25;
            if (pc !== RESET_PC) report_mismatch("pc", RESET_PC, pc);
            if (retire.valid !== 1'b0) report_mismatch("retire.valid", '0, W'(retire.valid));
            if (store.valid !== 1'b0) report_mismatch("store.valid", '0, W'(store.valid));
            @(negedge clk);
            // a register write and a store in turn, neither may show in reset
            if (i < 3) begin
                instr = (i % 2 == 0) ? RESET_WRITE_INSTR : RESET_STORE_INSTR;
            end
        end
        arst_n = 1'b1;

        w = 0;
        while (pc === RESET_PC && w < 8) begin
            run_cycle();
            w++;
        end
        if (pc === RESET_PC) begin
            errors++;
            $display("pc never left the reset value after reset release");
        end

        for (int c = 0; c < 2000; c++) run_cycle();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(100 * 2200);
        $display("timeout: the run did not finish in time");
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+common
common/cpu_pkg.sv
hw/control_unit.sv
hw/alu.sv
hw/reg_file.sv
hw/data_mem.sv
hw/result_select.sv
hw/cpu_top.sv
test/cpu_checker.sv
test/cpu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cpu testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cpu_tb -f verilog.f -o cpu_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/cpu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" sim.log; then
    echo "FAIL"
    exit 1
fi
echo "PASS"
exit 0
